// File: verilog/anchor_pkg.sv
package anchor_pkg;

  // octree shape
  localparam int tree_levels = 5;
  localparam int child_num   = 8;
  localparam int log_child   = 3;
  localparam int level_w     = 3;

  // level field on top, then one offset field per level, offset 0 highest
  localparam int pos_w = level_w + tree_levels * log_child;

  // total sibling groups over all levels, (8^5 - 1) / 7
  localparam int group_num = ((1 << (log_child * tree_levels)) - 1) / (child_num - 1);
  localparam int group_w   = $clog2(group_num);

  // sram word and lane layout
  localparam int data_w         = 64;
  localparam int addr_w         = 20;
  localparam int lane_w         = 16;
  localparam int lanes_per_word = data_w / lane_w;
  localparam int lane_sel_w     = $clog2(lanes_per_word);

  // memory map in words
  localparam int tree_base    = 0;
  localparam int feature_base = 8192;

  typedef enum logic {
    op_add = 1'b0,
    op_del = 1'b1
  } cmd_op_e;

endpackage

// File: verilog/node_addr_calc.sv
`timescale 1ns/10ps
module node_addr_calc (
  input  logic [anchor_pkg::pos_w-1:0]      calc_pos,
  input  logic [anchor_pkg::level_w-1:0]    calc_level,
  output logic [anchor_pkg::addr_w-1:0]     word_addr,
  output logic [anchor_pkg::lane_sel_w-1:0] lane,
  output logic [anchor_pkg::log_child-1:0]  slot,
  output logic [anchor_pkg::group_w-1:0]    group_idx
);
  import anchor_pkg::*;

  // msb of offset field 0 sits just below the level field
  localparam int field_top = pos_w - level_w;

  logic [group_w-1:0]   level_base;
  logic [group_w-1:0]   path_num;
  logic [log_child-1:0] field;

  always_comb begin
    level_base = '0;
    path_num   = '0;
    slot       = '0;
    field      = '0;
    for (int i = 0; i < tree_levels; i++) begin
      field = calc_pos[field_top - 1 - i * log_child -: log_child];
      if (i < int'(calc_level)) begin
        // parent path read as a base-8 number
        path_num   = group_w'(int'(path_num) * child_num + int'(field));
        // level base grows as 0, 1, 9, 73, 585
        level_base = group_w'(int'(level_base) * child_num + 1);
      end else if (i == int'(calc_level)) begin
        slot = field;
      end
    end
  end

  assign group_idx = level_base + path_num;
  assign word_addr = addr_w'(tree_base) + addr_w'(int'(group_idx) / lanes_per_word);
  assign lane      = lane_sel_w'(int'(group_idx) % lanes_per_word);

endmodule

// File: verilog/tree_walker.sv
`timescale 1ns/10ps
module tree_walker (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              walk_start,
  input  anchor_pkg::cmd_op_e               walk_op,
  input  logic [anchor_pkg::pos_w-1:0]      walk_pos,
  output logic                              walk_busy,
  output logic [anchor_pkg::pos_w-1:0]      calc_pos,
  output logic [anchor_pkg::level_w-1:0]    calc_level,
  input  logic [anchor_pkg::addr_w-1:0]     word_addr,
  input  logic [anchor_pkg::lane_sel_w-1:0] lane,
  input  logic [anchor_pkg::log_child-1:0]  slot,
  output logic                              wk_cen_n,
  output logic                              wk_gwen_n,
  output logic [anchor_pkg::addr_w-1:0]     wk_a,
  output logic [anchor_pkg::data_w-1:0]     wk_d,
  input  logic [anchor_pkg::data_w-1:0]     mem_q
);
  import anchor_pkg::*;

  localparam int sel_w = $clog2(data_w);

  typedef enum logic [1:0] {
    w_idle,
    w_read,
    w_write
  } walk_state_e;

  walk_state_e          state;
  cmd_op_e              op_q;
  logic [pos_w-1:0]     pos_q;
  logic [level_w-1:0]   level_q;
  logic                 self_q;
  logic [sel_w-1:0]     bit_sel;
  logic [data_w-1:0]    bit_mask;
  logic [data_w-1:0]    new_word;
  logic [lane_w-1:0]    old_lane;
  logic [lane_w-1:0]    new_lane;
  logic                 go_up;

  // show the new node to the calculator in the start cycle
  assign calc_pos   = walk_start ? walk_pos : pos_q;
  assign calc_level = walk_start ? walk_pos[pos_w-1 -: level_w] : level_q;

  always_comb begin
    // self bit is the odd one of the slot pair
    bit_sel  = sel_w'(int'(lane) * lane_w + int'(slot) * 2 + int'(self_q));
    bit_mask = data_w'(1) << bit_sel;
    if (op_q == op_add) begin
      new_word = mem_q | bit_mask;
    end else begin
      new_word = mem_q & ~bit_mask;
    end
    old_lane = mem_q[int'(lane) * lane_w +: lane_w];
    new_lane = new_word[int'(lane) * lane_w +: lane_w];
    // add climbs when the group was empty, delete when it became empty
    if (level_q == '0) begin
      go_up = 1'b0;
    end else if (op_q == op_add) begin
      go_up = (old_lane == '0);
    end else begin
      go_up = (new_lane == '0);
    end
  end

  assign walk_busy = (state != w_idle);
  assign wk_cen_n  = (state == w_idle);
  assign wk_gwen_n = (state != w_write);
  assign wk_a      = word_addr;
  assign wk_d      = new_word;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= w_idle;
      op_q    <= op_add;
      level_q <= '0;
      self_q  <= 1'b0;
    end else begin
      case (state)
        w_idle: begin
          if (walk_start) begin
            op_q    <= walk_op;
            level_q <= walk_pos[pos_w-1 -: level_w];
            self_q  <= 1'b1;
            state   <= w_read;
          end
        end
        w_read: begin
          state <= w_write;
        end
        w_write: begin
          if (go_up) begin
            // ancestors only get their child bit
            level_q <= level_q - 1'b1;
            self_q  <= 1'b0;
            state   <= w_read;
          end else begin
            state <= w_idle;
          end
        end
        default: begin
          state <= w_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (walk_start && state == w_idle) begin
      pos_q <= walk_pos;
    end
  end

endmodule

// File: verilog/feature_buffer.sv
`timescale 1ns/10ps
module feature_buffer #(
  parameter int feature_len = 9,
  localparam int idx_w = $clog2(feature_len + 1)
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          feat_valid,
  output logic                          feat_ready,
  input  logic [anchor_pkg::data_w-1:0] feat_data,
  input  logic                          buf_clear,
  output logic                          buf_full,
  input  logic [idx_w-1:0]              rd_idx,
  output logic [anchor_pkg::data_w-1:0] rd_data,
  input  logic                          armed
);
  import anchor_pkg::*;

  logic [data_w-1:0] words [feature_len];
  logic [idx_w-1:0]  wr_cnt;
  logic              beat;

  assign feat_ready = armed && !buf_full;
  assign beat       = feat_valid && feat_ready;
  assign rd_data    = words[rd_idx];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_cnt   <= '0;
      buf_full <= 1'b0;
    end else if (buf_clear) begin
      wr_cnt   <= '0;
      buf_full <= 1'b0;
    end else if (beat) begin
      wr_cnt <= wr_cnt + 1'b1;
      // full goes high right after the last beat
      buf_full <= (wr_cnt == idx_w'(feature_len - 1));
    end
  end

  always_ff @(posedge clk) begin
    if (beat) begin
      words[wr_cnt] <= feat_data;
    end
  end

endmodule

// File: verilog/update_ctrl.sv
`timescale 1ns/10ps
module update_ctrl #(
  parameter int feature_len = 9,
  localparam int idx_w = $clog2(feature_len + 1)
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             cmd_valid,
  output logic                             cmd_ready,
  input  anchor_pkg::cmd_op_e              cmd_op,
  input  logic [anchor_pkg::pos_w-1:0]     cmd_pos,
  output logic                             done,
  output anchor_pkg::cmd_op_e              done_op,
  output logic                             mem_cen_n,
  output logic                             mem_gwen_n,
  output logic [anchor_pkg::addr_w-1:0]    mem_a,
  output logic [anchor_pkg::data_w-1:0]    mem_d,
  output logic                             walk_start,
  output anchor_pkg::cmd_op_e              walk_op,
  output logic [anchor_pkg::pos_w-1:0]     walk_pos,
  input  logic                             walk_busy,
  input  logic                             wk_cen_n,
  input  logic                             wk_gwen_n,
  input  logic [anchor_pkg::addr_w-1:0]    wk_a,
  input  logic [anchor_pkg::data_w-1:0]    wk_d,
  input  logic                             buf_full,
  output logic                             buf_clear,
  output logic                             armed,
  output logic [idx_w-1:0]                 rd_idx,
  input  logic [anchor_pkg::data_w-1:0]    rd_data,
  input  logic [anchor_pkg::group_w-1:0]   feat_group,
  input  logic [anchor_pkg::log_child-1:0] feat_slot
);
  import anchor_pkg::*;

  typedef enum logic [2:0] {
    s_idle,
    s_walk,
    s_wait_features,
    s_write_features,
    s_finish
  } ctrl_state_e;

  ctrl_state_e          state;
  cmd_op_e              op_q;
  logic [group_w-1:0]   group_q;
  logic [log_child-1:0] slot_q;
  logic                 accept;
  logic                 walk_end;
  logic                 last_word;
  logic [addr_w-1:0]    feat_addr;

  assign accept     = cmd_valid && cmd_ready;
  assign walk_start = accept;
  assign walk_op    = cmd_op;
  assign walk_pos   = cmd_pos;

  assign walk_end  = (state == s_walk) && !walk_busy;
  assign last_word = (rd_idx == idx_w'(feature_len - 1));

  // a delete finishes as soon as the walker drops busy
  assign done      = (state == s_finish) || (walk_end && op_q == op_del);
  assign done_op   = op_q;
  assign buf_clear = (state == s_finish);

  // feature slot of the node, one run of feature_len words per child
  assign feat_addr = addr_w'(feature_base)
                   + (addr_w'(group_q) * addr_w'(child_num) + addr_w'(slot_q))
                     * addr_w'(feature_len)
                   + addr_w'(rd_idx);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= s_idle;
      op_q      <= op_add;
      cmd_ready <= 1'b0;
      armed     <= 1'b0;
      rd_idx    <= '0;
    end else begin
      if (accept) begin
        cmd_ready <= 1'b0;
      end else if (done || state == s_idle) begin
        cmd_ready <= 1'b1;
      end

      if (accept && cmd_op == op_add) begin
        armed <= 1'b1;
      end else if (buf_full) begin
        armed <= 1'b0;
      end

      case (state)
        s_idle: begin
          if (accept) begin
            op_q  <= cmd_op;
            state <= s_walk;
          end
        end
        s_walk: begin
          if (!walk_busy) begin
            if (op_q == op_add) begin
              state <= buf_full ? s_write_features : s_wait_features;
            end else begin
              state <= s_idle;
            end
          end
        end
        s_wait_features: begin
          // sram stays idle until the last feature word is in
          if (buf_full) begin
            state <= s_write_features;
          end
        end
        s_write_features: begin
          if (last_word) begin
            rd_idx <= '0;
            state  <= s_finish;
          end else begin
            rd_idx <= rd_idx + 1'b1;
          end
        end
        s_finish: begin
          state <= s_idle;
        end
        default: begin
          state <= s_idle;
        end
      endcase
    end
  end

  // node location is valid on the calculator in the accept cycle
  always_ff @(posedge clk) begin
    if (accept) begin
      group_q <= feat_group;
      slot_q  <= feat_slot;
    end
  end

  // single sram port, walker and feature writer never overlap
  always_comb begin
    case (state)
      s_walk: begin
        mem_cen_n  = wk_cen_n;
        mem_gwen_n = wk_gwen_n;
        mem_a      = wk_a;
        mem_d      = wk_d;
      end
      s_write_features: begin
        mem_cen_n  = 1'b0;
        mem_gwen_n = 1'b0;
        mem_a      = feat_addr;
        mem_d      = rd_data;
      end
      default: begin
        mem_cen_n  = 1'b1;
        mem_gwen_n = 1'b1;
        mem_a      = '0;
        mem_d      = '0;
      end
    endcase
  end

endmodule

// File: verilog/anchor_updater.sv
`timescale 1ns/10ps
module anchor_updater #(
  parameter int feature_len = 9
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          cmd_valid,
  output logic                          cmd_ready,
  input  anchor_pkg::cmd_op_e           cmd_op,
  input  logic [anchor_pkg::pos_w-1:0]  cmd_pos,
  input  logic                          feat_valid,
  output logic                          feat_ready,
  input  logic [anchor_pkg::data_w-1:0] feat_data,
  output logic                          done,
  output anchor_pkg::cmd_op_e           done_op,
  output logic                          mem_cen_n,
  output logic                          mem_gwen_n,
  output logic [anchor_pkg::addr_w-1:0] mem_a,
  output logic [anchor_pkg::data_w-1:0] mem_d,
  input  logic [anchor_pkg::data_w-1:0] mem_q
);
  import anchor_pkg::*;

  localparam int idx_w = $clog2(feature_len + 1);

  // controller to walker
  logic                 walk_start;
  cmd_op_e              walk_op;
  logic [pos_w-1:0]     walk_pos;
  logic                 walk_busy;
  logic                 wk_cen_n;
  logic                 wk_gwen_n;
  logic [addr_w-1:0]    wk_a;
  logic [data_w-1:0]    wk_d;

  // walker to address calculator
  logic [pos_w-1:0]      calc_pos;
  logic [level_w-1:0]    calc_level;
  logic [addr_w-1:0]     word_addr;
  logic [lane_sel_w-1:0] lane;
  logic [log_child-1:0]  slot;
  logic [group_w-1:0]    group_idx;

  // feature buffer
  logic                 buf_full;
  logic                 buf_clear;
  logic                 armed;
  logic [idx_w-1:0]     rd_idx;
  logic [data_w-1:0]    rd_data;

  update_ctrl #(
    .feature_len(feature_len)
  ) u_update_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd_op    (cmd_op),
    .cmd_pos   (cmd_pos),
    .done      (done),
    .done_op   (done_op),
    .mem_cen_n (mem_cen_n),
    .mem_gwen_n(mem_gwen_n),
    .mem_a     (mem_a),
    .mem_d     (mem_d),
    .walk_start(walk_start),
    .walk_op   (walk_op),
    .walk_pos  (walk_pos),
    .walk_busy (walk_busy),
    .wk_cen_n  (wk_cen_n),
    .wk_gwen_n (wk_gwen_n),
    .wk_a      (wk_a),
    .wk_d      (wk_d),
    .buf_full  (buf_full),
    .buf_clear (buf_clear),
    .armed     (armed),
    .rd_idx    (rd_idx),
    .rd_data   (rd_data),
    .feat_group(group_idx),
    .feat_slot (slot)
  );

  tree_walker u_tree_walker (
    .clk       (clk),
    .rst_n     (rst_n),
    .walk_start(walk_start),
    .walk_op   (walk_op),
    .walk_pos  (walk_pos),
    .walk_busy (walk_busy),
    .calc_pos  (calc_pos),
    .calc_level(calc_level),
    .word_addr (word_addr),
    .lane      (lane),
    .slot      (slot),
    .wk_cen_n  (wk_cen_n),
    .wk_gwen_n (wk_gwen_n),
    .wk_a      (wk_a),
    .wk_d      (wk_d),
    .mem_q     (mem_q)
  );

  node_addr_calc u_node_addr_calc (
    .calc_pos  (calc_pos),
    .calc_level(calc_level),
    .word_addr (word_addr),
    .lane      (lane),
    .slot      (slot),
    .group_idx (group_idx)
  );

  feature_buffer #(
    .feature_len(feature_len)
  ) u_feature_buffer (
    .clk       (clk),
    .rst_n     (rst_n),
    .feat_valid(feat_valid),
    .feat_ready(feat_ready),
    .feat_data (feat_data),
    .buf_clear (buf_clear),
    .buf_full  (buf_full),
    .rd_idx    (rd_idx),
    .rd_data   (rd_data),
    .armed     (armed)
  );

endmodule

// File: bench/sram_model.sv
`timescale 1ns/10ps
module sram_model (
  input  logic                          clk,
  input  logic                          cen_n,
  input  logic                          gwen_n,
  input  logic [anchor_pkg::addr_w-1:0] a,
  input  logic [anchor_pkg::data_w-1:0] d,
  output logic [anchor_pkg::data_w-1:0] q
);
  import anchor_pkg::*;

  // only touched words take storage, the rest reads as zero
  logic [data_w-1:0] mem [logic [addr_w-1:0]];
  logic [data_w-1:0] rd_q = '0;

  assign q = rd_q;

  // q holds its value through write cycles
  always @(posedge clk) begin
    if (!cen_n) begin
      if (!gwen_n) begin
        mem[a] = d;
      end else if (mem.exists(a)) begin
        rd_q <= mem[a];
      end else begin
        rd_q <= '0;
      end
    end
  end

endmodule

// File: bench/tb_anchor_updater.sv
`timescale 1ns/10ps
module tb_anchor_updater;
  import anchor_pkg::*;

  localparam int feature_len  = 9;
  localparam int num_ops      = 200;
  localparam int seed         = 32'h98b9;
  localparam int op_cycles    = 2 * tree_levels + feature_len + 20;
  localparam int fixed_cycles = 400;
  localparam int max_cycles   = num_ops * op_cycles + fixed_cycles;

  logic              clk = 1'b0;
  logic              rst_n;
  logic              cmd_valid;
  logic              cmd_ready;
  cmd_op_e           cmd_op;
  logic [pos_w-1:0]  cmd_pos;
  logic              feat_valid;
  logic              feat_ready;
  logic [data_w-1:0] feat_data;
  logic              done;
  cmd_op_e           done_op;
  logic              mem_cen_n;
  logic              mem_gwen_n;
  logic [addr_w-1:0] mem_a;
  logic [data_w-1:0] mem_d;
  logic [data_w-1:0] mem_q;

  // reference model state
  logic [data_w-1:0] model_mem [int unsigned];
  logic [addr_w-1:0] exp_addr [$];
  logic [data_w-1:0] exp_data [$];

  // monitor state
  int      obs_cnt      = 0;
  int      mon_errs     = 0;
  int      done_cnt     = 0;
  int      cur_tree_wr  = 0;
  int      cur_feat_wr  = 0;
  int      last_tree_wr = 0;
  int      last_feat_wr = 0;
  bit      pending      = 1'b0;
  cmd_op_e acc_op       = op_add;
  int      cycles       = 0;

  // test bookkeeping
  int seq_errs     = 0;
  int tests_run    = 0;
  int tests_failed = 0;

  always #4 clk = ~clk;

  anchor_updater #(
    .feature_len(feature_len)
  ) u_anchor_updater (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd_op    (cmd_op),
    .cmd_pos   (cmd_pos),
    .feat_valid(feat_valid),
    .feat_ready(feat_ready),
    .feat_data (feat_data),
    .done      (done),
    .done_op   (done_op),
    .mem_cen_n (mem_cen_n),
    .mem_gwen_n(mem_gwen_n),
    .mem_a     (mem_a),
    .mem_d     (mem_d),
    .mem_q     (mem_q)
  );

  sram_model u_sram_model (
    .clk   (clk),
    .cen_n (mem_cen_n),
    .gwen_n(mem_gwen_n),
    .a     (mem_a),
    .d     (mem_d),
    .q     (mem_q)
  );

  function automatic int level_of(input logic [pos_w-1:0] pos);
    return int'(pos[pos_w-1 -: level_w]);
  endfunction

  function automatic int offset_of(input logic [pos_w-1:0] pos, input int idx);
    return int'((pos >> (pos_w - level_w - log_child * (idx + 1))) & 7);
  endfunction

  // level base (8^L - 1) / 7 plus the parent path in base 8
  function automatic int group_of(input logic [pos_w-1:0] pos, input int lvl);
    int path;
    path = 0;
    for (int i = 0; i < lvl; i++) begin
      path = path * child_num + offset_of(pos, i);
    end
    return ((child_num ** lvl) - 1) / (child_num - 1) + path;
  endfunction

  function automatic logic [pos_w-1:0] make_pos(input int lvl, input int o0, input int o1,
                                                input int o2, input int o3, input int o4);
    return {level_w'(lvl), log_child'(o0), log_child'(o1), log_child'(o2), log_child'(o3),
            log_child'(o4)};
  endfunction

  // small position space so adds and deletes collide often
  function automatic logic [pos_w-1:0] random_pos();
    return make_pos($urandom % tree_levels, $urandom % 2, $urandom % 2, $urandom % 2,
                    $urandom % 2, $urandom % 2);
  endfunction

  function automatic logic [data_w-1:0] model_word(input int unsigned addr);
    if (model_mem.exists(addr)) begin
      return model_mem[addr];
    end
    return '0;
  endfunction

  function automatic int total_errors();
    return mon_errs + seq_errs;
  endfunction

  task automatic model_tree_walk(input cmd_op_e op, input logic [pos_w-1:0] pos);
    int                lvl;
    int                grp;
    int unsigned       addr;
    int                lane;
    int                bit_idx;
    logic [data_w-1:0] old_w;
    logic [data_w-1:0] new_w;
    logic [lane_w-1:0] old_lane;
    logic [lane_w-1:0] new_lane;
    bit                climb;
    lvl   = level_of(pos);
    climb = 1'b1;
    while (climb) begin
      grp  = group_of(pos, lvl);
      addr = tree_base + grp / (data_w / lane_w);
      lane = grp % (data_w / lane_w);
      // the node gets its self bit, ancestors their child bit
      bit_idx = lane * lane_w + offset_of(pos, lvl) * 2 + ((lvl == level_of(pos)) ? 1 : 0);
      old_w   = model_word(addr);
      if (op == op_add) begin
        new_w = old_w | (data_w'(1) << bit_idx);
      end else begin
        new_w = old_w & ~(data_w'(1) << bit_idx);
      end
      model_mem[addr] = new_w;
      exp_addr.push_back(addr_w'(addr));
      exp_data.push_back(new_w);
      old_lane = old_w[lane * lane_w +: lane_w];
      new_lane = new_w[lane * lane_w +: lane_w];
      if (lvl == 0) begin
        climb = 1'b0;
      end else if (op == op_add) begin
        climb = (old_lane == '0);
      end else begin
        climb = (new_lane == '0);
      end
      lvl--;
    end
  endtask

  // one command from model update to done with random gaps on both streams
  task automatic run_cmd(input cmd_op_e op, input logic [pos_w-1:0] pos);
    logic [data_w-1:0] words [feature_len];
    int                node_grp;
    int                node_slot;
    int unsigned       addr;
    int                target;
    node_grp  = group_of(pos, level_of(pos));
    node_slot = offset_of(pos, level_of(pos));
    model_tree_walk(op, pos);
    if (op == op_add) begin
      for (int k = 0; k < feature_len; k++) begin
        words[k] = {$urandom, $urandom};
        addr     = feature_base + (node_grp * child_num + node_slot) * feature_len + k;
        model_mem[addr] = words[k];
        exp_addr.push_back(addr_w'(addr));
        exp_data.push_back(words[k]);
      end
    end
    target = done_cnt + 1;
    repeat ($urandom % 4) @(negedge clk);
    cmd_valid = 1'b1;
    cmd_op    = op;
    cmd_pos   = pos;
    @(posedge clk);
    while (!cmd_ready) @(posedge clk);
    @(negedge clk);
    cmd_valid = 1'b0;
    if (op == op_add) begin
      for (int k = 0; k < feature_len; k++) begin
        repeat ($urandom % 3) @(negedge clk);
        feat_valid = 1'b1;
        feat_data  = words[k];
        @(posedge clk);
        while (!feat_ready) @(posedge clk);
        @(negedge clk);
        feat_valid = 1'b0;
      end
    end
    while (done_cnt < target) @(negedge clk);
  endtask

  task automatic expect_writes(input string what, input int tree_exp, input int feat_exp);
    assert (last_tree_wr == tree_exp && last_feat_wr == feat_exp) else begin
      $display("** Error at %0t: %s made %0d tree and %0d feature writes, expected %0d and %0d",
               $time, what, last_tree_wr, last_feat_wr, tree_exp, feat_exp);
      seq_errs++;
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    int errs;
    errs = total_errors() - errs_before;
    tests_run++;
    if (errs == 0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errs);
    end
  endtask

  // watches the sram port and the handshake outputs on every edge
  always @(posedge clk) begin
    if (rst_n) begin
      if (!mem_cen_n && !mem_gwen_n) begin
        assert (obs_cnt < exp_addr.size()) else begin
          $display("SRAM wrote address %0h when no write was expected", mem_a);
          mon_errs++;
        end
        if (obs_cnt < exp_addr.size()) begin
          assert (mem_a == exp_addr[obs_cnt] && mem_d == exp_data[obs_cnt]) else begin
            $display("** Error at %0t: write %0d got [%0h] = %0h, expected [%0h] = %0h",
                     $time, obs_cnt, mem_a, mem_d, exp_addr[obs_cnt], exp_data[obs_cnt]);
            mon_errs++;
          end
          obs_cnt++;
        end
        if (mem_a < addr_w'(feature_base)) begin
          cur_tree_wr++;
        end else begin
          cur_feat_wr++;
        end
      end
      if (!pending) begin
        assert (mem_cen_n && mem_gwen_n && !done) else begin
          $display("SRAM or done was active at %0t with no command in progress", $time);
          mon_errs++;
        end
      end else begin
        assert (!cmd_ready) else begin
          $display("cmd_ready was high at %0t while a command was in progress", $time);
          mon_errs++;
        end
      end
      // feature words are only taken for an add in progress
      if (feat_ready) begin
        assert (pending && acc_op == op_add) else begin
          $display("feat_ready was high at %0t with no add in progress", $time);
          mon_errs++;
        end
      end
      if (done) begin
        assert (done_op == acc_op) else begin
          $display("** Error at %0t: done_op %0d, expected %0d", $time, done_op, acc_op);
          mon_errs++;
        end
        assert (obs_cnt == exp_addr.size()) else begin
          $display("done came at %0t before all expected SRAM writes were seen", $time);
          mon_errs++;
        end
        last_tree_wr = cur_tree_wr;
        last_feat_wr = cur_feat_wr;
        done_cnt++;
        pending = 1'b0;
      end
      if (cmd_valid && cmd_ready) begin
        pending     = 1'b1;
        acc_op      = cmd_op;
        cur_tree_wr = 0;
        cur_feat_wr = 0;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", max_cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  initial begin
    int      base;
    cmd_op_e op;
    void'($urandom(seed));
    rst_n      = 1'b0;
    cmd_valid  = 1'b0;
    cmd_op     = op_add;
    cmd_pos    = '0;
    feat_valid = 1'b0;
    feat_data  = '0;

    // reset values and idle port before any command
    base = total_errors();
    @(negedge clk);
    assert (!cmd_ready && !done && !feat_ready && mem_cen_n && mem_gwen_n) else begin
      $display("outputs were not at their reset values during reset");
      seq_errs++;
    end
    @(negedge clk);
    rst_n = 1'b1;
    repeat (10) begin
      @(posedge clk);
      assert (!feat_ready) else begin
        $display("feat_ready was high at %0t with no add in progress", $time);
        seq_errs++;
      end
    end
    @(negedge clk);
    assert (cmd_ready) else begin
      $display("cmd_ready did not rise after reset");
      seq_errs++;
    end
    finish_test("reset_idle", base);

    base = total_errors();
    run_cmd(op_add, make_pos(4, 3, 5, 1, 6, 2));
    expect_writes("add into empty tree", 5, feature_len);
    finish_test("add_chain", base);

    base = total_errors();
    run_cmd(op_add, make_pos(4, 3, 5, 1, 6, 7));
    expect_writes("add of a sibling", 1, feature_len);
    finish_test("add_sibling", base);

    // new branch that joins the root group next to the first chain
    base = total_errors();
    run_cmd(op_add, make_pos(2, 6, 0, 4, 0, 0));
    expect_writes("add on a new branch", 3, feature_len);
    finish_test("feature_gaps", base);

    base = total_errors();
    run_cmd(op_del, make_pos(4, 3, 5, 1, 6, 7));
    expect_writes("delete with live sibling", 1, 0);
    run_cmd(op_del, make_pos(4, 3, 5, 1, 6, 2));
    expect_writes("delete of chain node", 5, 0);
    finish_test("delete_chain", base);

    base = total_errors();
    for (int n = 0; n < num_ops; n++) begin
      op = ($urandom % 5 < 3) ? op_add : op_del;
      run_cmd(op, random_pos());
    end
    finish_test("random_mix", base);

    $display("tests run %0d, failed %0d, errors %0d, sram writes %0d",
             tests_run, tests_failed, total_errors(), obs_cnt);
    if (tests_failed == 0 && total_errors() == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: all.f
verilog/anchor_pkg.sv
verilog/node_addr_calc.sv
verilog/tree_walker.sv
verilog/feature_buffer.sv
verilog/update_ctrl.sv
verilog/anchor_updater.sv
bench/sram_model.sv
bench/tb_anchor_updater.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -Wno-fatal
TOP       := tb_anchor_updater
FILELIST  := all.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
